// ==== logic/stats_pkg.sv ====
`default_nettype none

package stats_pkg;

    localparam int STAT_W      = 32;
    localparam int STAT_ADDR_W = 30;
    localparam int REG_OFFS_W  = 8;
    localparam int BLOCK_SEL_W = 4;

    localparam logic [BLOCK_SEL_W-1:0] TOP_BLOCK = '0;
    localparam logic [STAT_W-1:0]      DEAD_WORD = 32'hDEADBEEF;

    // Handshake bits of one stream tap
    typedef struct packed {
        logic valid;
        logic ready;
        logic eop;
    } stream_tap_t;

    typedef enum logic [1:0] {
        ACTION_DROP    = 2'd0,
        ACTION_MATCH   = 2'd1,
        ACTION_NOMATCH = 2'd2,
        ACTION_CHECK   = 2'd3
    } pdu_action_e;

    typedef struct packed {
        pdu_action_e action;
        logic [25:0] flow_tag;
    } pdu_meta_t;

    // Register map with fill maximums from REG_MAX_FILL_BASE up
    typedef enum logic [REG_OFFS_W-1:0] {
        REG_IN_PKT          = 0,
        REG_OUT_PKT         = 1,
        REG_OUT_1_PKT       = 2,
        REG_CPU_NOMATCH_PKT = 3,
        REG_CPU_MATCH_PKT   = 4,
        REG_CTRL            = 5,
        REG_MAX_FILL_BASE   = 16
    } reg_offs_e;

    typedef struct packed {
        logic [STAT_W-1:0] in_pkt;
        logic [STAT_W-1:0] out_pkt;
        logic [STAT_W-1:0] out_1_pkt;
    } pkt_counts_t;

    typedef struct packed {
        logic [STAT_W-1:0] nomatch;
        logic [STAT_W-1:0] match;
    } meta_counts_t;

endpackage

`default_nettype wire

// ==== logic/stream_pkt_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_pkt_counters
    import stats_pkg::*;
(
    input  wire logic        clk_status,
    input  wire logic        rst,
    input  wire stream_tap_t in_tap_i,
    input  wire stream_tap_t out_tap_i,
    input  wire stream_tap_t out_1_tap_i,
    output pkt_counts_t      pkt_counts_o
);

    // Last beat of a packet taken by the sink
    function automatic logic pkt_done(stream_tap_t tap);
        return tap.valid & tap.ready & tap.eop;
    endfunction

    // eop driven on an idle bus
    function automatic logic stray_eop(stream_tap_t tap);
        return tap.eop & ~tap.valid;
    endfunction

    //////////////////////////////
    // Packet counters
    //////////////////////////////

    always_ff @(posedge clk_status) begin
        if (rst) begin
            pkt_counts_o <= '0;
        end else begin
            if (pkt_done(in_tap_i)) begin
                pkt_counts_o.in_pkt <= pkt_counts_o.in_pkt + 1'b1;
            end
            if (pkt_done(out_tap_i)) begin
                pkt_counts_o.out_pkt <= pkt_counts_o.out_pkt + 1'b1;
            end
            if (pkt_done(out_1_tap_i)) begin
                pkt_counts_o.out_1_pkt <= pkt_counts_o.out_1_pkt + 1'b1;
            end
        end
    end

    // Sources must qualify eop with valid on every tap
    a_eop_needs_valid: assert property (
        @(posedge clk_status) disable iff (rst)
        !(stray_eop(in_tap_i) || stray_eop(out_tap_i) || stray_eop(out_1_tap_i))
    ) else $error("eop seen on a stream tap without valid");

endmodule

`default_nettype wire

// ==== logic/cpu_meta_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_meta_counters
    import stats_pkg::*;
(
    input  wire logic      clk_status,
    input  wire logic      rst,
    input  wire pdu_meta_t pdu_meta_i,
    input  wire logic      pdu_meta_valid_i,
    input  wire logic      pdu_meta_ready_i,
    output meta_counts_t   meta_counts_o
);

    logic meta_accept;

    assign meta_accept = pdu_meta_valid_i & pdu_meta_ready_i;

    always_ff @(posedge clk_status) begin
        if (rst) begin
            meta_counts_o <= '0;
        end else if (meta_accept) begin
            case (pdu_meta_i.action)
                ACTION_MATCH: begin
                    meta_counts_o.match <= meta_counts_o.match + 1'b1;
                end
                ACTION_NOMATCH: begin
                    meta_counts_o.nomatch <= meta_counts_o.nomatch + 1'b1;
                end
                // Drop and check records are not counted here
                default: begin
                end
            endcase
        end
    end

    a_action_known: assert property (
        @(posedge clk_status) disable iff (rst)
        meta_accept |-> !$isunknown(pdu_meta_i.action)
    ) else $error("CPU metadata accepted with unknown action");

endmodule

`default_nettype wire

// ==== logic/fifo_watermarks.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_watermarks
    import stats_pkg::*;
#(
    parameter int NUM_FIFOS = 5,
    parameter int FILL_W    = 16
) (
    input  wire logic                           clk_status,
    input  wire logic                           rst,
    input  wire logic [NUM_FIFOS-1:0][FILL_W-1:0] fill_levels_i,
    output logic      [NUM_FIFOS-1:0][FILL_W-1:0] watermarks_o
);

    // Running maximum per FIFO
    always_ff @(posedge clk_status) begin
        if (rst) begin
            watermarks_o <= '0;
        end else begin
            for (int i = 0; i < NUM_FIFOS; i++) begin
                if (fill_levels_i[i] > watermarks_o[i]) begin
                    watermarks_o[i] <= fill_levels_i[i];
                end
            end
        end
    end

    for (genvar g = 0; g < NUM_FIFOS; g++) begin : g_mark_chk
        a_no_decrease: assert property (
            @(posedge clk_status) disable iff (rst)
            watermarks_o[g] >= $past(watermarks_o[g])
        ) else $error("watermark %0d decreased", g);
    end

    // Width must fit in a status word
    initial begin
        assert (FILL_W <= STAT_W) else $fatal(1, "FILL_W wider than status word");
    end

endmodule

`default_nettype wire

// ==== logic/status_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_regs
    import stats_pkg::*;
#(
    parameter int NUM_FIFOS = 5,
    parameter int FILL_W    = 16
) (
    input  wire logic                             clk_status,
    input  wire logic                             rst,
    input  wire pkt_counts_t                      pkt_counts_i,
    input  wire meta_counts_t                     meta_counts_i,
    input  wire logic [NUM_FIFOS-1:0][FILL_W-1:0] watermarks_i,
    input  wire logic [STAT_ADDR_W-1:0]           status_addr_i,
    input  wire logic                             status_read_i,
    input  wire logic                             status_write_i,
    input  wire logic [STAT_W-1:0]                status_writedata_i,
    output logic      [STAT_W-1:0]                status_readdata_o,
    output logic                                  status_readdata_valid_o,
    output logic      [STAT_W-1:0]                ctrl_o
);

    logic [BLOCK_SEL_W-1:0] blk_q;
    logic [REG_OFFS_W-1:0]  offs_q;
    logic                   read_q;
    logic                   write_q;
    logic [STAT_W-1:0]      wdata_q;
    logic                   in_block;
    logic [REG_OFFS_W-1:0]  fill_idx;
    logic [STAT_W-1:0]      read_word;
    logic                   rd_req_in_block;

    //////////////////////////////
    // Request stage
    //////////////////////////////

    always_ff @(posedge clk_status) begin
        if (rst) begin
            read_q  <= 1'b0;
            write_q <= 1'b0;
        end else begin
            read_q  <= status_read_i;
            write_q <= status_write_i;
        end
    end

    always_ff @(posedge clk_status) begin
        blk_q   <= status_addr_i[STAT_ADDR_W-1 -: BLOCK_SEL_W];
        offs_q  <= status_addr_i[REG_OFFS_W-1:0];
        wdata_q <= status_writedata_i;
    end

    assign in_block = (blk_q == TOP_BLOCK);
    assign fill_idx = offs_q - REG_MAX_FILL_BASE;

    // Register select
    always_comb begin
        case (offs_q)
            REG_IN_PKT:          read_word = pkt_counts_i.in_pkt;
            REG_OUT_PKT:         read_word = pkt_counts_i.out_pkt;
            REG_OUT_1_PKT:       read_word = pkt_counts_i.out_1_pkt;
            REG_CPU_NOMATCH_PKT: read_word = meta_counts_i.nomatch;
            REG_CPU_MATCH_PKT:   read_word = meta_counts_i.match;
            REG_CTRL:            read_word = ctrl_o;
            default: begin
                if (offs_q >= REG_MAX_FILL_BASE &&
                    offs_q < REG_MAX_FILL_BASE + NUM_FIFOS) begin
                    read_word = STAT_W'(watermarks_i[fill_idx]);
                end else begin
                    read_word = DEAD_WORD;
                end
            end
        endcase
    end

    //////////////////////////////
    // Response and control
    //////////////////////////////

    always_ff @(posedge clk_status) begin
        if (rst) begin
            status_readdata_valid_o <= 1'b0;
            ctrl_o                  <= '0;
        end else begin
            status_readdata_valid_o <= read_q & in_block;
            // Writes to other offsets are dropped
            if (write_q && in_block && offs_q == REG_CTRL) begin
                ctrl_o <= wdata_q;
            end
        end
    end

    always_ff @(posedge clk_status) begin
        if (read_q && in_block) begin
            status_readdata_o <= read_word;
        end
    end

    assign rd_req_in_block = status_read_i &&
                             (status_addr_i[STAT_ADDR_W-1 -: BLOCK_SEL_W] == TOP_BLOCK);

    // One response per in-block read, two edges after the strobe
    a_read_latency: assert property (
        @(posedge clk_status) disable iff (rst)
        status_readdata_valid_o == $past(rd_req_in_block, 2)
    ) else $error("status read response out of step with request");

endmodule

`default_nettype wire

// ==== logic/pipeline_stats_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_stats_top
    import stats_pkg::*;
#(
    parameter int NUM_FIFOS = 5,
    parameter int FILL_W    = 16
) (
    input  wire logic                             clk_status,
    input  wire logic                             rst,
    input  wire stream_tap_t                      in_tap_i,
    input  wire stream_tap_t                      out_tap_i,
    input  wire stream_tap_t                      out_1_tap_i,
    input  wire pdu_meta_t                        pdu_meta_i,
    input  wire logic                             pdu_meta_valid_i,
    input  wire logic                             pdu_meta_ready_i,
    input  wire logic [NUM_FIFOS-1:0][FILL_W-1:0] fill_levels_i,
    input  wire logic [STAT_ADDR_W-1:0]           status_addr_i,
    input  wire logic                             status_read_i,
    input  wire logic                             status_write_i,
    input  wire logic [STAT_W-1:0]                status_writedata_i,
    output logic      [STAT_W-1:0]                status_readdata_o,
    output logic                                  status_readdata_valid_o,
    output logic      [STAT_W-1:0]                ctrl_o
);

    pkt_counts_t                      pkt_counts;
    meta_counts_t                     meta_counts;
    logic [NUM_FIFOS-1:0][FILL_W-1:0] watermarks;

    stream_pkt_counters u_pkt_cnt (
        .clk_status   (clk_status),
        .rst          (rst),
        .in_tap_i     (in_tap_i),
        .out_tap_i    (out_tap_i),
        .out_1_tap_i  (out_1_tap_i),
        .pkt_counts_o (pkt_counts)
    );

    cpu_meta_counters u_meta_cnt (
        .clk_status       (clk_status),
        .rst              (rst),
        .pdu_meta_i       (pdu_meta_i),
        .pdu_meta_valid_i (pdu_meta_valid_i),
        .pdu_meta_ready_i (pdu_meta_ready_i),
        .meta_counts_o    (meta_counts)
    );

    fifo_watermarks #(
        .NUM_FIFOS (NUM_FIFOS),
        .FILL_W    (FILL_W)
    ) u_marks (
        .clk_status    (clk_status),
        .rst           (rst),
        .fill_levels_i (fill_levels_i),
        .watermarks_o  (watermarks)
    );

    status_regs #(
        .NUM_FIFOS (NUM_FIFOS),
        .FILL_W    (FILL_W)
    ) u_regs (
        .clk_status              (clk_status),
        .rst                     (rst),
        .pkt_counts_i            (pkt_counts),
        .meta_counts_i           (meta_counts),
        .watermarks_i            (watermarks),
        .status_addr_i           (status_addr_i),
        .status_read_i           (status_read_i),
        .status_write_i          (status_write_i),
        .status_writedata_i      (status_writedata_i),
        .status_readdata_o       (status_readdata_o),
        .status_readdata_valid_o (status_readdata_valid_o),
        .ctrl_o                  (ctrl_o)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 16
) (
    output logic clk_status_o,
    output logic rst_o
);

    initial begin
        clk_status_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_status_o = ~clk_status_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_status_o);
        @(negedge clk_status_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tests/tb_pipeline_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_stats
    import stats_pkg::*;
();

    localparam int NUM_FIFOS  = 5;
    localparam int FILL_W     = 16;
    localparam int MAX_CYCLES = 4000;

    logic clk_status;
    logic rst;
    stream_tap_t in_tap, out_tap, out_1_tap;
    pdu_meta_t pdu_meta;
    logic pdu_meta_valid, pdu_meta_ready;
    logic [NUM_FIFOS-1:0][FILL_W-1:0] fill_levels;
    logic [STAT_ADDR_W-1:0] status_addr;
    logic status_read, status_write;
    logic [STAT_W-1:0] status_writedata, status_readdata, ctrl;
    logic status_readdata_valid;

    // Reference model
    logic [STAT_W-1:0] exp_pkt [3];
    logic [STAT_W-1:0] exp_match, exp_nomatch;
    logic [FILL_W-1:0] exp_max [NUM_FIFOS];
    logic [STAT_W-1:0] ctrl_model = '0;
    logic exp_rd = 1'b0, exp_rd_d1 = 1'b0, exp_rd_d2 = 1'b0;
    logic [STAT_W-1:0] exp_word = '0, exp_word_d1 = '0, exp_word_d2 = '0;
    logic [STAT_W-1:0] ctrl_d1 = '0, ctrl_d2 = '0;

    logic [31:0] lcg_state = 32'hfc37_9187;
    int err_cnt = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int cycle_cnt = 0;

    tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(16)) u_clk (
        .clk_status_o (clk_status),
        .rst_o        (rst)
    );

    pipeline_stats_top #(.NUM_FIFOS(NUM_FIFOS), .FILL_W(FILL_W)) u_dut (
        .clk_status              (clk_status),
        .rst                     (rst),
        .in_tap_i                (in_tap),
        .out_tap_i               (out_tap),
        .out_1_tap_i             (out_1_tap),
        .pdu_meta_i              (pdu_meta),
        .pdu_meta_valid_i        (pdu_meta_valid),
        .pdu_meta_ready_i        (pdu_meta_ready),
        .fill_levels_i           (fill_levels),
        .status_addr_i           (status_addr),
        .status_read_i           (status_read),
        .status_write_i          (status_write),
        .status_writedata_i      (status_writedata),
        .status_readdata_o       (status_readdata),
        .status_readdata_valid_o (status_readdata_valid),
        .ctrl_o                  (ctrl)
    );

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic stream_tap_t random_tap();
        logic [31:0] r;
        stream_tap_t t;
        r = rand_word();
        t.valid = r[20] | r[21];
        t.ready = r[22] | r[23];
        t.eop   = t.valid & (r[25:24] == 2'd0);
        return t;
    endfunction

    function automatic logic pkt_complete(stream_tap_t t);
        return t.valid & t.ready & t.eop;
    endfunction

    function automatic logic [STAT_ADDR_W-1:0] make_addr(int blk, int offs);
        return {BLOCK_SEL_W'(blk), (STAT_ADDR_W-BLOCK_SEL_W-REG_OFFS_W)'(0), REG_OFFS_W'(offs)};
    endfunction

    // Register map as seen from the status port
    function automatic logic [STAT_W-1:0] expected_reg(int offs);
        if (offs >= 16 && offs < 16 + NUM_FIFOS) begin
            return STAT_W'(exp_max[offs - 16]);
        end
        case (offs)
            0: return exp_pkt[0];
            1: return exp_pkt[1];
            2: return exp_pkt[2];
            3: return exp_nomatch;
            4: return exp_match;
            5: return ctrl_model;
            default: return DEAD_WORD;
        endcase
    endfunction

    task automatic issue_read(int blk, int offs);
        status_addr = make_addr(blk, offs);
        status_read = 1'b1;
        exp_rd      = (blk == 0);
        exp_word    = expected_reg(offs);
        @(negedge clk_status);
        status_read = 1'b0;
        exp_rd      = 1'b0;
    endtask

    task automatic read_reg(int blk, int offs);
        issue_read(blk, offs);
        repeat (2) @(negedge clk_status);
    endtask

    task automatic write_reg(int blk, int offs, logic [STAT_W-1:0] data);
        status_addr      = make_addr(blk, offs);
        status_writedata = data;
        status_write     = 1'b1;
        if (blk == 0 && offs == 5) begin
            ctrl_model = data;
        end
        @(negedge clk_status);
        status_write = 1'b0;
    endtask

    task automatic report_test(string name, int errs_before);
        if (err_cnt == errs_before) begin
            tests_ok++;
            $display("test %0s: ok", name);
        end else begin
            tests_bad++;
            $display("test %0s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////

    always @(posedge clk_status) begin
        exp_rd_d1   <= exp_rd;
        exp_rd_d2   <= exp_rd_d1;
        exp_word_d1 <= exp_word;
        exp_word_d2 <= exp_word_d1;
        ctrl_d1     <= ctrl_model;
        ctrl_d2     <= ctrl_d1;
    end

    a_read_valid: assert property (@(posedge clk_status) disable iff (rst)
        status_readdata_valid == exp_rd_d2)
    else begin
        err_cnt++;
        $display("ERR status_readdata_valid_o expected %h actual %h",
                 $sampled(exp_rd_d2), $sampled(status_readdata_valid));
    end

    a_read_data: assert property (@(posedge clk_status) disable iff (rst)
        status_readdata_valid |-> status_readdata == exp_word_d2)
    else begin
        err_cnt++;
        $display("ERR status_readdata_o expected %h actual %h",
                 $sampled(exp_word_d2), $sampled(status_readdata));
    end

    a_ctrl: assert property (@(posedge clk_status) disable iff (rst) ctrl == ctrl_d2)
    else begin
        err_cnt++;
        $display("ERR ctrl_o expected %h actual %h", $sampled(ctrl_d2), $sampled(ctrl));
    end

    always @(posedge clk_status) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        int errs;
        logic [31:0] r;
        logic [FILL_W-1:0] lvl;
        int seq[$];
        in_tap = '0;
        out_tap = '0;
        out_1_tap = '0;
        pdu_meta = '0;
        pdu_meta_valid = 1'b0;
        pdu_meta_ready = 1'b0;
        fill_levels = '0;
        status_addr = '0;
        status_read = 1'b0;
        status_write = 1'b0;
        status_writedata = '0;
        exp_pkt = '{default: '0};
        exp_match = '0;
        exp_nomatch = '0;
        for (int i = 0; i < NUM_FIFOS; i++) exp_max[i] = '0;
        @(negedge clk_status);
        wait (rst == 1'b0);
        repeat (4) @(negedge clk_status);

        // Reset values
        errs = err_cnt;
        seq = '{0, 1, 2, 3, 4, 5, 16, 17, 18, 19, 20};
        foreach (seq[k]) read_reg(0, seq[k]);
        report_test("reset values", errs);

        // Stream taps with stalls
        errs = err_cnt;
        repeat (600) begin
            in_tap = random_tap();
            out_tap = random_tap();
            out_1_tap = random_tap();
            if (pkt_complete(in_tap)) exp_pkt[0]++;
            if (pkt_complete(out_tap)) exp_pkt[1]++;
            if (pkt_complete(out_1_tap)) exp_pkt[2]++;
            @(negedge clk_status);
        end
        in_tap = '0;
        out_tap = '0;
        out_1_tap = '0;
        @(negedge clk_status);
        for (int k = 0; k < 3; k++) read_reg(0, k);
        report_test("packet counts", errs);

        // CPU metadata with all four actions
        errs = err_cnt;
        repeat (400) begin
            r = rand_word();
            pdu_meta.action = pdu_action_e'(r[17:16]);
            pdu_meta.flow_tag = r[31:6];
            pdu_meta_valid = r[18] | r[19];
            pdu_meta_ready = r[20];
            if (pdu_meta_valid && pdu_meta_ready) begin
                if (pdu_meta.action == ACTION_MATCH) exp_match++;
                if (pdu_meta.action == ACTION_NOMATCH) exp_nomatch++;
            end
            @(negedge clk_status);
        end
        pdu_meta_valid = 1'b0;
        @(negedge clk_status);
        read_reg(0, REG_CPU_NOMATCH_PKT);
        read_reg(0, REG_CPU_MATCH_PKT);
        report_test("metadata counts", errs);

        // Fill levels under a ceiling that grows over the test
        errs = err_cnt;
        for (int n = 0; n < 400; n++) begin
            for (int i = 0; i < NUM_FIFOS; i++) begin
                r = rand_word();
                lvl = r[31:16] % (16'(n) * 16'd150 + 16'd1);
                fill_levels[i] = lvl;
                if (lvl > exp_max[i]) exp_max[i] = lvl;
            end
            @(negedge clk_status);
        end
        fill_levels = '0;
        @(negedge clk_status);
        for (int i = 0; i < NUM_FIFOS; i++) read_reg(0, 16 + i);
        report_test("fill maximums", errs);

        // Control register and address decode
        errs = err_cnt;
        write_reg(0, REG_CTRL, rand_word());
        read_reg(0, REG_CTRL);
        write_reg(0, REG_CPU_MATCH_PKT, rand_word());
        write_reg(2, REG_CTRL, rand_word());
        repeat (3) @(negedge clk_status);
        read_reg(0, REG_CTRL);
        read_reg(0, 8);
        read_reg(0, 16 + NUM_FIFOS);
        read_reg(3, REG_IN_PKT);
        read_reg(15, REG_CTRL);
        report_test("control and decode", errs);

        // Back-to-back reads
        errs = err_cnt;
        seq = '{0, 1, 2, 3, 4, 16, 5, 9, 20, 0};
        foreach (seq[k]) issue_read(0, seq[k]);
        repeat (3) @(negedge clk_status);
        report_test("back-to-back reads", errs);

        $display("tests ok %0d, tests failed %0d, check errors %0d",
                 tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pipeline_stats_top.f ====
logic/stats_pkg.sv
logic/stream_pkt_counters.sv
logic/cpu_meta_counters.sv
logic/fifo_watermarks.sv
logic/status_regs.sv
logic/pipeline_stats_top.sv
tests/tb_clk_gen.sv
tests/tb_pipeline_stats.sv

// ==== Bender.yml ====
package:
  name: pipeline_stats_top

sources:
  - logic/stats_pkg.sv
  - logic/stream_pkt_counters.sv
  - logic/cpu_meta_counters.sv
  - logic/fifo_watermarks.sv
  - logic/status_regs.sv
  - logic/pipeline_stats_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_pipeline_stats.sv
